// ==== rt_pkg.sv ====
package rt_pkg;

    // signed fixed point, 8 integer bits and 24 fraction bits
    typedef logic signed [31:0] fp;

    typedef struct packed {
        fp x;
        fp y;
        fp z;
    } vec3;

    // screen coordinate, enough for 0..639
    typedef logic [9:0] pixel_coord;

    localparam int FP_FRAC = 24;
    localparam fp FP_ONE = 32'h0100_0000;
    localparam fp FP_HALF = 32'h0080_0000;
    // saturation value for 1/sqrt(0) and overflow
    localparam fp FP_MAX = 32'h7fff_ffff;

    localparam int SCREEN_W = 640;
    localparam int SCREEN_H = 480;

    // 2/640, rounded up from 52428.8
    localparam fp SCALE_X = 32'h0000_cccd;
    // 2/480
    localparam fp SCALE_Y = 32'h0001_1111;
    // 4/3
    localparam fp ASPECT_RATIO = 32'h0155_5555;

    // normalize, seed, two newton iterations at two stages each, shift back
    localparam int INV_SQRT_ITERS = 2;
    localparam int INV_SQRT_LAT = 7;
    // ndc, ray, magnitude, then inv_sqrt
    localparam int RAYGEN_LAT = 10;
    // width of the frame_done timer in the scanner
    localparam int DONE_CNT_W = $clog2(RAYGEN_LAT + 1);

    // truncating fixed-point product
    function automatic fp fp_mul(fp a, fp b);
        logic signed [63:0] prod;
        prod = a * b;
        return fp'(prod >>> FP_FRAC);
    endfunction

    function automatic fp vec3_dot(vec3 a, vec3 b);
        return fp_mul(a.x, b.x) + fp_mul(a.y, b.y) + fp_mul(a.z, b.z);
    endfunction

    function automatic vec3 make_vec3(fp x, fp y, fp z);
        vec3 v;
        v.x = x;
        v.y = y;
        v.z = z;
        return v;
    endfunction

    // camera looks down z, axes fixed
    localparam vec3 CAMERA_RIGHT = make_vec3(FP_ONE, 32'sd0, 32'sd0);
    localparam vec3 CAMERA_UP = make_vec3(32'sd0, FP_ONE, 32'sd0);

    // 1/sqrt seeds at bucket midpoints, 16 fraction bits
    // entries 0..31 cover [1,2) in steps of 1/32, entries 32..63 cover [2,4) in 1/16
    function automatic logic [63:0][15:0] make_seed_table();
        logic [63:0][15:0] seeds;
        longint m_q16;
        longint y_q16;
        longint trial;
        for (int i = 0; i < 64; i++) begin
            if (i < 32) begin
                m_q16 = 65536 + i * 2048 + 1024;
            end else begin
                m_q16 = 131072 + (i - 32) * 4096 + 2048;
            end
            // bisection on y with y*y*m <= 1
            y_q16 = 0;
            for (int b = 15; b >= 0; b--) begin
                trial = y_q16 | (longint'(1) << b);
                if (trial * trial * m_q16 <= (longint'(1) << 48)) begin
                    y_q16 = trial;
                end
            end
            seeds[i] = y_q16[15:0];
        end
        return seeds;
    endfunction

    localparam logic [63:0][15:0] INV_SQRT_SEEDS = make_seed_table();

endpackage

// ==== pipe_delay.sv ====
module pipe_delay #(
    parameter int DEPTH = 1,
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst,
    input  T     d,
    output T     q
);

    // one register per cycle of delay
    T stages [DEPTH];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= d;
            // shift toward the tail
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    // oldest entry
    assign q = stages[DEPTH-1];

endmodule

// ==== inv_sqrt.sv ====
module inv_sqrt (
    input  logic     clk,
    input  logic     rst,
    input  logic     valid_in,
    input  rt_pkg::fp x,
    output rt_pkg::fp inv_sqrt,
    output logic     valid_out
);
    import rt_pkg::*;

    // stage 1 combinational
    logic [4:0]        msb;
    logic signed [5:0] norm_shift;
    logic signed [4:0] half_shift;
    fp                 x_norm;
    // stage 2 combinational
    logic [5:0]        seed_idx;
    // stage 7 combinational
    logic [63:0]       y_wide;

    logic [INV_SQRT_LAT-1:0] valid_sr;

    // payload pipeline
    fp                 m_s    [1:2*INV_SQRT_ITERS];
    logic signed [4:0] sh_s   [1:2*INV_SQRT_ITERS+2];
    logic              zero_s [1:2*INV_SQRT_ITERS+2];
    fp                 y_s    [0:INV_SQRT_ITERS];
    fp                 ya_s   [0:INV_SQRT_ITERS-1];
    fp                 h_s    [0:INV_SQRT_ITERS-1];

    // leading one of a positive input
    always_comb begin
        msb = '0;
        for (int i = 0; i < 31; i++) begin
            if (x[i]) begin
                msb = 5'(i);
            end
        end
        // distance from bit 24, floored to even so the root shift is whole
        norm_shift = $signed({1'b0, msb}) - 6'sd24;
        norm_shift[0] = 1'b0;
        half_shift = 5'(norm_shift >>> 1);
        // mantissa lands in [1,4)
        if (norm_shift >= 0) begin
            x_norm = x >> norm_shift;
        end else begin
            x_norm = x << (-norm_shift);
        end
    end

    // 32 buckets per octave
    always_comb begin
        if (m_s[1][25]) begin
            seed_idx = {1'b1, m_s[1][24:20]};
        end else begin
            seed_idx = {1'b0, m_s[1][23:19]};
        end
    end

    // y * 2^-shift, left shifts can overflow
    always_comb begin
        y_wide = {32'b0, y_s[INV_SQRT_ITERS]};
        if (sh_s[2*INV_SQRT_ITERS+2] >= 0) begin
            y_wide = y_wide >> sh_s[2*INV_SQRT_ITERS+2];
        end else begin
            y_wide = y_wide << (-sh_s[2*INV_SQRT_ITERS+2]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[INV_SQRT_LAT-2:0], valid_in};
        end
    end

    assign valid_out = valid_sr[INV_SQRT_LAT-1];

    always_ff @(posedge clk) begin
        // stage 1
        m_s[1] <= x_norm;
        sh_s[1] <= half_shift;
        zero_s[1] <= (x <= 0);
        // exponent and zero flag ride along to the last stage
        for (int k = 2; k <= 2 * INV_SQRT_ITERS + 2; k++) begin
            sh_s[k] <= sh_s[k-1];
            zero_s[k] <= zero_s[k-1];
        end
        for (int k = 2; k <= 2 * INV_SQRT_ITERS; k++) begin
            m_s[k] <= m_s[k-1];
        end
        // stage 2, seed widened to 24 fraction bits
        y_s[0] <= fp'({INV_SQRT_SEEDS[seed_idx], 8'b0});
        // newton, y' = y * (3/2 - m/2 * y^2)
        for (int it = 0; it < INV_SQRT_ITERS; it++) begin
            h_s[it] <= fp_mul(m_s[2 + 2*it] >>> 1, fp_mul(y_s[it], y_s[it]));
            ya_s[it] <= y_s[it];
            y_s[it+1] <= fp_mul(ya_s[it], FP_ONE + FP_HALF - h_s[it]);
        end
        // stage 7
        if (zero_s[2*INV_SQRT_ITERS+2] || (y_wide > 64'(FP_MAX))) begin
            inv_sqrt <= FP_MAX;
        end else begin
            inv_sqrt <= fp'(y_wide[31:0]);
        end
    end

endmodule

// ==== ray_generator.sv ====
module ray_generator (
    input  logic               clk,
    input  logic               rst,
    input  rt_pkg::pixel_coord screen_x,
    input  rt_pkg::pixel_coord screen_y,
    input  logic               valid_in,
    input  rt_pkg::vec3        camera_forward,
    output rt_pkg::vec3        ray_direction,
    output logic               valid_out
);
    import rt_pkg::*;

    // pixel centres scaled into [0,2)
    fp    centre_x;
    fp    centre_y;
    fp    ndc_x;
    fp    ndc_y;
    logic valid_r1;
    logic valid_r2;
    logic valid_r3;
    vec3  ray;
    vec3  ray_dly;
    fp    ray_mag_sq;
    fp    inv_ray_mag;

    // one camera axis component of the ray
    function automatic fp axis_mix(fp nx, fp ny, fp right, fp up, fp fwd);
        return fp_mul(nx, right) + fp_mul(ny, up) - fwd;
    endfunction

    // (2p+1)/2 * scale, coordinate never held as fp
    always_comb begin
        centre_x = (fp'({screen_x, 1'b1}) * SCALE_X) >>> 1;
        centre_y = (fp'({screen_y, 1'b1}) * SCALE_Y) >>> 1;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_r1 <= 1'b0;
            valid_r2 <= 1'b0;
            valid_r3 <= 1'b0;
        end else begin
            valid_r1 <= valid_in;
            valid_r2 <= valid_r1;
            valid_r3 <= valid_r2;
        end
    end

    always_ff @(posedge clk) begin
        // stage 1, ndc in [-1,1], x stretched by the aspect ratio
        if (valid_in) begin
            ndc_x <= fp_mul(centre_x - FP_ONE, ASPECT_RATIO);
            ndc_y <= FP_ONE - centre_y;
        end
        // stage 2, camera space equals world space
        if (valid_r1) begin
            ray <= make_vec3(
                axis_mix(ndc_x, ndc_y, CAMERA_RIGHT.x, CAMERA_UP.x, camera_forward.x),
                axis_mix(ndc_x, ndc_y, CAMERA_RIGHT.y, CAMERA_UP.y, camera_forward.y),
                axis_mix(ndc_x, ndc_y, CAMERA_RIGHT.z, CAMERA_UP.z, camera_forward.z));
        end
        // stage 3
        if (valid_r2) begin
            ray_mag_sq <= vec3_dot(ray, ray);
        end
    end

    inv_sqrt i_inv_sqrt (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_r3),
        .x         (ray_mag_sq),
        .inv_sqrt  (inv_ray_mag),
        .valid_out (valid_out)
    );

    // ray is one stage ahead of the magnitude, so one extra slot
    pipe_delay #(
        .DEPTH (INV_SQRT_LAT + 1),
        .T     (vec3)
    ) i_ray_delay (
        .clk (clk),
        .rst (rst),
        .d   (ray),
        .q   (ray_dly)
    );

    // normalize multiply hangs off the inv_sqrt output register
    assign ray_direction = make_vec3(
        fp_mul(ray_dly.x, inv_ray_mag),
        fp_mul(ray_dly.y, inv_ray_mag),
        fp_mul(ray_dly.z, inv_ray_mag));

endmodule

// ==== pixel_scanner.sv ====
module pixel_scanner (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    output rt_pkg::pixel_coord pixel_x,
    output rt_pkg::pixel_coord pixel_y,
    output logic               pixel_valid,
    output logic               busy,
    output logic               frame_done
);
    import rt_pkg::*;

    logic                  last_col;
    logic                  last_row;
    logic                  last_pixel;
    // counts down to the cycle of the last ray
    logic [DONE_CNT_W-1:0] done_cnt;

    assign last_col = (pixel_x == pixel_coord'(SCREEN_W - 1));
    assign last_row = (pixel_y == pixel_coord'(SCREEN_H - 1));
    assign last_pixel = busy && last_col && last_row;

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy <= 1'b0;
            pixel_x <= '0;
            pixel_y <= '0;
            done_cnt <= '0;
        end else begin
            if (!busy) begin
                // start is only taken between frames
                if (start) begin
                    busy <= 1'b1;
                    pixel_x <= '0;
                    pixel_y <= '0;
                end
            end else if (last_col) begin
                pixel_x <= '0;
                if (last_row) begin
                    pixel_y <= '0;
                    busy <= 1'b0;
                end else begin
                    pixel_y <= pixel_y + 1'b1;
                end
            end else begin
                pixel_x <= pixel_x + 1'b1;
            end
            if (last_pixel) begin
                done_cnt <= DONE_CNT_W'(RAYGEN_LAT);
            end else if (done_cnt != '0) begin
                done_cnt <= done_cnt - 1'b1;
            end
        end
    end

    // every busy cycle carries a pixel
    assign pixel_valid = busy;
    // reaches 1 exactly RAYGEN_LAT cycles after the last strobe
    assign frame_done = (done_cnt == DONE_CNT_W'(1));

endmodule

// ==== ray_front_end.sv ====
module ray_front_end (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  rt_pkg::vec3        camera_forward,
    output rt_pkg::vec3        ray_direction,
    output rt_pkg::pixel_coord ray_pixel_x,
    output rt_pkg::pixel_coord ray_pixel_y,
    output logic               ray_valid,
    output logic               busy,
    output logic               frame_done
);
    import rt_pkg::*;

    // coordinates travel beside the ray
    typedef struct packed {
        pixel_coord x;
        pixel_coord y;
    } pixel_pair;

    pixel_coord pixel_x;
    pixel_coord pixel_y;
    logic       pixel_valid;
    pixel_pair  pair_in;
    pixel_pair  pair_out;

    pixel_scanner i_scanner (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .pixel_valid (pixel_valid),
        .busy        (busy),
        .frame_done  (frame_done)
    );

    ray_generator i_raygen (
        .clk            (clk),
        .rst            (rst),
        .screen_x       (pixel_x),
        .screen_y       (pixel_y),
        .valid_in       (pixel_valid),
        .camera_forward (camera_forward),
        .ray_direction  (ray_direction),
        .valid_out      (ray_valid)
    );

    assign pair_in.x = pixel_x;
    assign pair_in.y = pixel_y;

    // matched to the generator latency
    pipe_delay #(
        .DEPTH (RAYGEN_LAT),
        .T     (pixel_pair)
    ) i_coord_delay (
        .clk (clk),
        .rst (rst),
        .d   (pair_in),
        .q   (pair_out)
    );

    assign ray_pixel_x = pair_out.x;
    assign ray_pixel_y = pair_out.y;

endmodule

// ==== ray_front_end_props.sv ====
module ray_front_end_props (
    input logic clk,
    input logic rst,
    input logic start,
    input logic pixel_valid,
    input logic busy,
    input logic ray_valid,
    input logic frame_done
);
    timeunit 1ns;
    timeprecision 100ps;
    import rt_pkg::*;

    // ray strobe trails the pixel strobe by the generator latency
    // once the whole window lies after reset
    assert property (@(posedge clk) disable iff (!rst)
        $past(rst, RAYGEN_LAT) |-> ray_valid == $past(pixel_valid, RAYGEN_LAT))
        else $error("ray_valid is not pixel_valid delayed by RAYGEN_LAT cycles");

    // single-cycle pulse
    assert property (@(posedge clk) disable iff (!rst) frame_done |=> !frame_done)
        else $error("frame_done was high for two cycles running");

    // a frame opens only on a start taken while idle
    assert property (@(posedge clk) disable iff (!rst)
        $rose(pixel_valid) |-> $past(start && !busy))
        else $error("pixel_valid rose without a start taken while idle");

endmodule

bind ray_front_end ray_front_end_props i_props (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .pixel_valid (pixel_valid),
    .busy        (busy),
    .ray_valid   (ray_valid),
    .frame_done  (frame_done)
);

// ==== tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    // 8 ns period
    localparam real HALF_PERIOD = 4.0;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // active low, released just after an edge
    initial begin
        rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b1;
    end

endmodule

// ==== tb_ray_front_end.sv ====
module tb_ray_front_end;
    timeunit 1ns;
    timeprecision 100ps;
    import rt_pkg::*;

    localparam int FRAME_PIXELS = SCREEN_W * SCREEN_H;
    // three frames plus slack for reset, idle checks and latency
    localparam int TIMEOUT_CYCLES = 3 * FRAME_PIXELS + 1000;
    localparam int SAMPLES = 200;
    // start cycle to first ray cycle
    localparam int START_TO_RAY = 11;
    localparam real FP_SCALE = 16777216.0;
    localparam real VEC_TOL = 1.0 / 4096.0;
    localparam real LEN_TOL = 1.0 / 1024.0;

    logic       clk;
    logic       rst;
    logic       start;
    vec3        camera_forward;
    vec3        ray_direction;
    pixel_coord ray_pixel_x;
    pixel_coord ray_pixel_y;
    logic       ray_valid;
    logic       busy;
    logic       frame_done;

    // monitor state
    int         frame_no;
    int         ray_count;
    int         done_count;
    int         cycle_count;
    int         start_cycle;
    int         first_ray_cycle;
    int         errors;
    string      test_name;
    pixel_coord exp_x;
    pixel_coord exp_y;
    bit         sample_pixel [FRAME_PIXELS];

    tb_clock_gen i_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    ray_front_end i_dut (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .camera_forward (camera_forward),
        .ray_direction  (ray_direction),
        .ray_pixel_x    (ray_pixel_x),
        .ray_pixel_y    (ray_pixel_y),
        .ray_valid      (ray_valid),
        .busy           (busy),
        .frame_done     (frame_done)
    );

    task automatic fail_run(string what);
        errors++;
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic real to_real(fp v);
        return $itor(v) / FP_SCALE;
    endfunction

    function automatic fp to_fp(real r);
        return fp'($rtoi(r * FP_SCALE));
    endfunction

    task automatic check_flag(string name, logic exp, logic act);
        if (exp !== act) begin
            fail_run($sformatf("ERROR %s, %s: expected %b, actual %b",
                test_name, name, exp, act));
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (exp != act) begin
            fail_run($sformatf("ERROR %s, %s: expected %0d, actual %0d",
                test_name, name, exp, act));
        end
    endtask

    task automatic check_coord(string name, pixel_coord exp, pixel_coord act);
        if (exp !== act) begin
            fail_run($sformatf("ERROR %s, %s: expected %0d, actual %0d",
                test_name, name, exp, act));
        end
    endtask

    // per-component tolerance
    task automatic check_vec3(string name, vec3 exp, vec3 act);
        real dx;
        real dy;
        real dz;
        dx = to_real(exp.x) - to_real(act.x);
        dy = to_real(exp.y) - to_real(act.y);
        dz = to_real(exp.z) - to_real(act.z);
        if (dx > VEC_TOL || dx < -VEC_TOL || dy > VEC_TOL || dy < -VEC_TOL
                || dz > VEC_TOL || dz < -VEC_TOL) begin
            fail_run($sformatf("ERROR %s, %s: expected (%f,%f,%f), actual (%f,%f,%f)",
                test_name, name,
                to_real(exp.x), to_real(exp.y), to_real(exp.z),
                to_real(act.x), to_real(act.y), to_real(act.z)));
        end
    endtask

    task automatic check_length(string name, vec3 act);
        real len;
        len = $sqrt(to_real(act.x) ** 2 + to_real(act.y) ** 2 + to_real(act.z) ** 2);
        if (len > 1.0 + LEN_TOL || len < 1.0 - LEN_TOL) begin
            fail_run($sformatf("ERROR %s, %s: expected length 1.0, actual %f",
                test_name, name, len));
        end
    endtask

    // real-valued pixel to unit ray
    function automatic vec3 model_ray(int px, int py, vec3 fwd);
        real nx;
        real ny;
        real rx;
        real ry;
        real rz;
        real len;
        vec3 v;
        nx = ((px + 0.5) * 2.0 / 640.0 - 1.0) * 4.0 / 3.0;
        ny = 1.0 - (py + 0.5) * 2.0 / 480.0;
        rx = nx - to_real(fwd.x);
        ry = ny - to_real(fwd.y);
        rz = 0.0 - to_real(fwd.z);
        len = $sqrt(rx * rx + ry * ry + rz * rz);
        v.x = to_fp(rx / len);
        v.y = to_fp(ry / len);
        v.z = to_fp(rz / len);
        return v;
    endfunction

    // corners and centre in frame 1 and random picks in frame 2
    function automatic bit is_sampled(int frame, int px, int py);
        if (frame == 1) begin
            return ((px == 0 || px == 639) && (py == 0 || py == 479)) || (px == 320 && py == 240);
        end
        if (frame == 2) begin
            return sample_pixel[py * 640 + px];
        end
        return 1'b0;
    endfunction

    // magnitude 0.5..1 with either sign
    function automatic fp random_component();
        real mag;
        mag = 0.5 + $urandom_range(0, 1000) / 2000.0;
        if ($urandom_range(0, 1) == 1) begin
            mag = -mag;
        end
        return to_fp(mag);
    endfunction

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (rst && ray_valid) begin
            if (ray_count == 0) begin
                first_ray_cycle = cycle_count;
            end
            check_coord("ray_pixel_x", exp_x, ray_pixel_x);
            check_coord("ray_pixel_y", exp_y, ray_pixel_y);
            check_length($sformatf("length at (%0d,%0d)", exp_x, exp_y), ray_direction);
            if (is_sampled(frame_no, int'(exp_x), int'(exp_y))) begin
                check_vec3($sformatf("ray (%0d,%0d) frame %0d", exp_x, exp_y, frame_no),
                    model_ray(int'(exp_x), int'(exp_y), camera_forward), ray_direction);
            end
            ray_count++;
            // raster order wrapping to (0,0) after the last pixel
            if (exp_x == 10'd639) begin
                exp_x = '0;
                exp_y = (exp_y == 10'd479) ? 10'd0 : exp_y + 10'd1;
            end else begin
                exp_x = exp_x + 10'd1;
            end
        end
        if (rst && frame_done) begin
            check_flag("ray_valid with frame_done", 1'b1, ray_valid);
            check_count("rays per frame", FRAME_PIXELS, ray_count);
            ray_count = 0;
            done_count++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout: the run did not finish within %0d cycles",
                TIMEOUT_CYCLES));
        end
    end

    task automatic start_frame(vec3 fwd, int frame);
        @(posedge clk);
        #1;
        camera_forward = fwd;
        frame_no = frame;
        start_cycle = cycle_count;
        start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
    endtask

    task automatic wait_frames(int target);
        wait (done_count >= target);
    endtask

    task automatic test_idle_after_reset();
        test_name = "idle_after_reset";
        repeat (20) begin
            @(negedge clk);
            check_flag("idle ray_valid", 1'b0, ray_valid);
            check_flag("idle busy", 1'b0, busy);
            check_flag("idle frame_done", 1'b0, frame_done);
        end
    endtask

    task automatic test_single_frame();
        vec3 fwd;
        test_name = "single_frame";
        fwd.x = '0;
        fwd.y = '0;
        fwd.z = to_fp(1.0);
        start_frame(fwd, 1);
        @(negedge clk);
        check_flag("busy after start", 1'b1, busy);
        wait_frames(1);
        check_count("frame 1 start to first ray", START_TO_RAY, first_ray_cycle - start_cycle);
        // no second pulse and no stray rays
        repeat (20) begin
            @(negedge clk);
            check_flag("ray_valid after frame", 1'b0, ray_valid);
        end
        check_count("frame_done pulses", 1, done_count);
        check_flag("busy after frame", 1'b0, busy);
    endtask

    task automatic test_random_frame();
        vec3 fwd;
        int  picked;
        int  idx;
        test_name = "random_frame";
        fwd.x = random_component();
        fwd.y = random_component();
        fwd.z = random_component();
        picked = 0;
        while (picked < SAMPLES) begin
            idx = int'($urandom_range(0, FRAME_PIXELS - 1));
            if (!sample_pixel[idx]) begin
                sample_pixel[idx] = 1'b1;
                picked++;
            end
        end
        start_frame(fwd, 2);
        // ignored start mid-frame
        repeat (1000) @(posedge clk);
        #1 start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        @(negedge clk);
        check_flag("busy after extra start", 1'b1, busy);
        wait_frames(2);
    endtask

    // start lands in the cycle after frame_done
    task automatic test_back_to_back();
        test_name = "back_to_back";
        start_frame(camera_forward, 3);
        wait_frames(3);
        check_count("frame 3 start to first ray", START_TO_RAY, first_ray_cycle - start_cycle);
    endtask

    initial begin
        void'($urandom(32'h9839));
        start = 1'b0;
        camera_forward = '0;
        frame_no = 0;
        ray_count = 0;
        done_count = 0;
        cycle_count = 0;
        start_cycle = 0;
        first_ray_cycle = 0;
        errors = 0;
        test_name = "startup";
        exp_x = '0;
        exp_y = '0;
        wait (rst === 1'b1);
        test_idle_after_reset();
        test_single_frame();
        test_random_frame();
        test_back_to_back();
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== project.f ====
rt_pkg.sv
pipe_delay.sv
inv_sqrt.sv
ray_generator.sv
pixel_scanner.sv
ray_front_end.sv
ray_front_end_props.sv
tb_clock_gen.sv
tb_ray_front_end.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ray_front_end
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
